/* rtl/issue_pkg.sv */
`default_nettype none

package issue_pkg;

    // R-format view of an instruction word.
    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    // I-format view of the same word.
    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    typedef struct packed {
        instr_u      instr;
        logic [31:0] pc;
    } fetch_entry_t;

    // Per-slot decode result seen by the issue logic.
    typedef struct packed {
        logic         en;
        logic [5:0]   op;
        logic [4:0]   rs;
        logic [4:0]   rt;
        logic         reg_wen;
        logic [4:0]   reg_waddr;
        logic         mem_en;
        logic         mem_to_reg;
        logic         is_branch;
        logic         is_hilo;
        logic         is_spec;       // COP0, syscall, break.
        fetch_entry_t entry;
    } slot_status_t;

    typedef struct packed {
        logic         valid;
        logic         in_delayslot;
        fetch_entry_t entry;
        logic         reg_wen;
        logic [4:0]   reg_waddr;
        logic         mem_to_reg;
    } issue_pkt_t;

    localparam logic [5:0] OP_R_TYPE  = 6'b000000;
    localparam logic [5:0] OP_REGIMM  = 6'b000001;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_BLEZ    = 6'b000110;
    localparam logic [5:0] OP_BGTZ    = 6'b000111;
    localparam logic [5:0] OP_COP0    = 6'b010000;

    localparam logic [5:0] FN_JR      = 6'b001000;
    localparam logic [5:0] FN_JALR    = 6'b001001;
    localparam logic [5:0] FN_SYSCALL = 6'b001100;
    localparam logic [5:0] FN_BREAK   = 6'b001101;
    localparam logic [5:0] FN_MFHI    = 6'b010000;
    localparam logic [5:0] FN_MTHI    = 6'b010001;
    localparam logic [5:0] FN_MFLO    = 6'b010010;
    localparam logic [5:0] FN_MTLO    = 6'b010011;
    localparam logic [5:0] FN_MULT    = 6'b011000;
    localparam logic [5:0] FN_MULTU   = 6'b011001;
    localparam logic [5:0] FN_DIV     = 6'b011010;
    localparam logic [5:0] FN_DIVU    = 6'b011011;

endpackage

`default_nettype wire

/* rtl/inst_queue.sv */
`default_nettype none
`timescale 1ns/1ps

module inst_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    push,
    input  logic                    push_two,
    input  issue_pkg::fetch_entry_t push_entry0,
    input  issue_pkg::fetch_entry_t push_entry1,
    input  logic                    pop,
    input  logic                    pop_two,
    output issue_pkg::fetch_entry_t head0,
    output issue_pkg::fetch_entry_t head1,
    output logic                    empty,
    output logic                    almost_empty,
    output logic                    space_two
);

    localparam int AW = $clog2(QUEUE_DEPTH);
    localparam logic [AW:0] MAX_FILL = (AW + 1)'(QUEUE_DEPTH - 2); // Room left for a pair.

    issue_pkg::fetch_entry_t mem [QUEUE_DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] wr_ptr_plus1;
    logic [AW-1:0] rd_ptr;
    logic [AW-1:0] rd_ptr_plus1;
    logic [AW:0]   count;
    logic [1:0]    push_cnt;
    logic [1:0]    pop_cnt;

    always_comb begin
        push_cnt = 2'd0;
        if (push) begin
            push_cnt = push_two ? 2'd2 : 2'd1;
        end
    end

    // pop_two only counts together with pop.
    always_comb begin
        pop_cnt = 2'd0;
        if (pop) begin
            pop_cnt = pop_two ? 2'd2 : 2'd1;
        end
    end

    assign wr_ptr_plus1 = wr_ptr + AW'(1);
    assign rd_ptr_plus1 = rd_ptr + AW'(1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + AW'(push_cnt);
            rd_ptr <= rd_ptr + AW'(pop_cnt);
            count  <= count + (AW + 1)'(push_cnt) - (AW + 1)'(pop_cnt);
        end
    end

    // Storage, no reset.
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_entry0;
            if (push_two) begin
                mem[wr_ptr_plus1] <= push_entry1;
            end
        end
    end

    assign head0 = mem[rd_ptr];
    assign head1 = mem[rd_ptr_plus1];

    assign empty        = (count == '0);
    assign almost_empty = (count == (AW + 1)'(1));
    assign space_two    = (count <= MAX_FILL);

endmodule

`default_nettype wire

/* rtl/inst_decode.sv */
`default_nettype none
`timescale 1ns/1ps

module inst_decode (
    input  issue_pkg::fetch_entry_t entry,
    input  logic                    valid,
    output issue_pkg::slot_status_t status
);

    issue_pkg::r_fmt_t rfmt;
    issue_pkg::i_fmt_t ifmt;

    logic is_rtype;
    logic is_muldiv;
    logic is_hilo_move;
    logic is_load;
    logic is_alu_imm;
    logic is_cond_branch;
    logic is_jump_reg;

    assign rfmt = entry.instr.r;
    assign ifmt = entry.instr.i;

    assign is_rtype = (rfmt.op == issue_pkg::OP_R_TYPE);

    assign is_muldiv = is_rtype && (rfmt.funct inside {issue_pkg::FN_MULT, issue_pkg::FN_MULTU,
                                                       issue_pkg::FN_DIV, issue_pkg::FN_DIVU});

    assign is_hilo_move = is_rtype && (rfmt.funct inside {issue_pkg::FN_MFHI, issue_pkg::FN_MTHI,
                                                          issue_pkg::FN_MFLO, issue_pkg::FN_MTLO});

    assign is_load    = ifmt.op[5] & ~ifmt.op[3];  // 100xxx loads, 101xxx stores.
    assign is_alu_imm = (ifmt.op[5:3] == 3'b001);

    assign is_cond_branch = ifmt.op inside {issue_pkg::OP_BEQ, issue_pkg::OP_BNE,
                                            issue_pkg::OP_BLEZ, issue_pkg::OP_BGTZ,
                                            issue_pkg::OP_REGIMM};

    assign is_jump_reg = is_rtype && (rfmt.funct inside {issue_pkg::FN_JR, issue_pkg::FN_JALR});

    always_comb begin
        status            = '0;
        status.en         = valid;
        status.op         = rfmt.op;
        status.rs         = rfmt.rs;
        status.rt         = rfmt.rt;
        status.entry      = entry;
        status.mem_en     = ifmt.op[5];
        status.mem_to_reg = is_load;
        status.is_branch  = is_cond_branch || is_jump_reg ||
                            (ifmt.op == issue_pkg::OP_J) || (ifmt.op == issue_pkg::OP_JAL);
        status.is_hilo    = is_muldiv || is_hilo_move;
        status.is_spec    = (rfmt.op == issue_pkg::OP_COP0) ||
                            (is_rtype && (rfmt.funct inside {issue_pkg::FN_SYSCALL,
                                                             issue_pkg::FN_BREAK}));

        // Destination register.
        if (is_rtype) begin
            status.reg_wen   = !is_muldiv && (rfmt.funct != issue_pkg::FN_JR);
            status.reg_waddr = rfmt.rd;
        end else if (is_load || is_alu_imm) begin
            status.reg_wen   = 1'b1;
            status.reg_waddr = ifmt.rt;
        end else if (ifmt.op == issue_pkg::OP_JAL) begin
            status.reg_wen   = 1'b1;
            status.reg_waddr = 5'd31;  // Link register.
        end
    end

endmodule

`default_nettype wire

/* rtl/issue_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

module issue_ctrl (
    input  issue_pkg::slot_status_t master,
    input  issue_pkg::slot_status_t slave,
    input  issue_pkg::issue_pkt_t   exe_master,
    input  logic                    fifo_empty,
    input  logic                    fifo_almost_empty,
    output logic                    slave_en,
    output logic                    slave_in_delayslot
);

    logic pair_ok;
    logic load_stall;
    logic fifo_ok;
    logic master_dst_live;

    assign fifo_ok = !(fifo_empty || fifo_almost_empty);  // Slave needs a second entry.

    assign master_dst_live = master.reg_wen && (master.reg_waddr != 5'd0);

    // Structural and RAW rules between the two slots.
    always_comb begin
        if (!master.en || master.mem_en || slave.mem_en || slave.is_branch ||
            slave.is_hilo || master.is_spec || slave.is_spec) begin
            pair_ok = 1'b0;
        end else if (master_dst_live) begin
            if (slave.op == issue_pkg::OP_R_TYPE) begin
                pair_ok = (slave.rs != master.reg_waddr) && (slave.rt != master.reg_waddr);
            end else begin
                pair_ok = (slave.rs != master.reg_waddr);
            end
        end else begin
            pair_ok = 1'b1;
        end
    end

    // Load in execute feeding the slave.
    always_comb begin
        load_stall = 1'b0;
        if (exe_master.valid && exe_master.mem_to_reg &&
            ((slave.rs == exe_master.reg_waddr) || (slave.rt == exe_master.reg_waddr))) begin
            load_stall = 1'b1;
        end
    end

    assign slave_en           = pair_ok && fifo_ok && !load_stall;
    assign slave_in_delayslot = master.is_branch && slave_en;

endmodule

`default_nettype wire

/* rtl/exe_latch.sv */
`default_nettype none
`timescale 1ns/1ps

module exe_latch (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    exe_ready,
    input  logic                    master_go,
    input  logic                    slave_go,
    input  issue_pkg::slot_status_t master,
    input  issue_pkg::slot_status_t slave,
    input  logic                    slave_in_delayslot,
    output issue_pkg::issue_pkt_t   exe_master,
    output issue_pkg::issue_pkt_t   exe_slave
);

    issue_pkg::issue_pkt_t master_pkt;
    issue_pkg::issue_pkt_t slave_pkt;

    logic ds_pending;  // A lone branch went out, its delay slot comes next.

    function automatic issue_pkg::issue_pkt_t to_pkt(
        input issue_pkg::slot_status_t st,
        input logic                    go,
        input logic                    in_ds
    );
        issue_pkg::issue_pkt_t pkt;
        pkt.valid        = go;
        pkt.in_delayslot = in_ds;
        pkt.entry        = st.entry;
        pkt.reg_wen      = st.reg_wen;
        pkt.reg_waddr    = st.reg_waddr;
        pkt.mem_to_reg   = st.mem_to_reg;
        return pkt;
    endfunction

    assign master_pkt = to_pkt(master, master_go, ds_pending);
    assign slave_pkt  = to_pkt(slave, slave_go, slave_in_delayslot);

    // Reset clears only the valid bits and the delay-slot tracker.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exe_master.valid <= 1'b0;
            exe_slave.valid  <= 1'b0;
            ds_pending       <= 1'b0;
        end else if (exe_ready) begin
            exe_master <= master_pkt;
            exe_slave  <= slave_pkt;
            if (master_go) begin
                ds_pending <= master.is_branch && !slave_go;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/dual_issue_top.sv */
`default_nettype none
`timescale 1ns/1ps

module dual_issue_top #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    fetch_valid,
    input  logic                    fetch_two,
    input  issue_pkg::fetch_entry_t fetch_entry0,
    input  issue_pkg::fetch_entry_t fetch_entry1,
    output logic                    fetch_ready,
    input  logic                    exe_ready,
    output issue_pkg::issue_pkt_t   exe_master,
    output issue_pkg::issue_pkt_t   exe_slave
);

    issue_pkg::fetch_entry_t head0;
    issue_pkg::fetch_entry_t head1;
    issue_pkg::slot_status_t master_status;
    issue_pkg::slot_status_t slave_status;

    logic push;
    logic empty;
    logic almost_empty;
    logic space_two;
    logic slave_en;
    logic slave_in_delayslot;
    logic issue_go;

    assign fetch_ready = space_two;
    assign push        = fetch_valid && fetch_ready;
    assign issue_go    = master_status.en && exe_ready;  // Nothing leaves while execute stalls.

    inst_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) inst_queue_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .push         (push),
        .push_two     (fetch_two),
        .push_entry0  (fetch_entry0),
        .push_entry1  (fetch_entry1),
        .pop          (issue_go),
        .pop_two      (slave_en),
        .head0        (head0),
        .head1        (head1),
        .empty        (empty),
        .almost_empty (almost_empty),
        .space_two    (space_two)
    );

    inst_decode master (
        .entry  (head0),
        .valid  (!empty),
        .status (master_status)
    );

    inst_decode slave (
        .entry  (head1),
        .valid  (!empty && !almost_empty),
        .status (slave_status)
    );

    issue_ctrl issue_ctrl_inst (
        .master             (master_status),
        .slave              (slave_status),
        .exe_master         (exe_master),
        .fifo_empty         (empty),
        .fifo_almost_empty  (almost_empty),
        .slave_en           (slave_en),
        .slave_in_delayslot (slave_in_delayslot)
    );

    exe_latch exe_latch_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .exe_ready          (exe_ready),
        .master_go          (issue_go),
        .slave_go           (slave_en),
        .master             (master_status),
        .slave              (slave_status),
        .slave_in_delayslot (slave_in_delayslot),
        .exe_master         (exe_master),
        .exe_slave          (exe_slave)
    );

endmodule

`default_nettype wire

/* sim/tb_issue_model.svh */
`ifndef TB_ISSUE_MODEL_SVH
`define TB_ISSUE_MODEL_SVH

// Instruction classes, taken straight from the opcode and funct fields.
function automatic bit accesses_memory(input logic [31:0] w);
    return w[31];
endfunction

function automatic bit is_load(input logic [31:0] w);
    return w[31:29] == 3'b100;
endfunction

function automatic bit is_branch(input logic [31:0] w);
    if (w[31:26] == issue_pkg::OP_R_TYPE) begin
        return w[5:0] inside {issue_pkg::FN_JR, issue_pkg::FN_JALR};
    end
    return w[31:26] inside {issue_pkg::OP_BEQ, issue_pkg::OP_BNE, issue_pkg::OP_BLEZ,
                            issue_pkg::OP_BGTZ, issue_pkg::OP_REGIMM, issue_pkg::OP_J,
                            issue_pkg::OP_JAL};
endfunction

function automatic bit is_muldiv(input logic [31:0] w);
    return (w[31:26] == issue_pkg::OP_R_TYPE) && (w[5:0] inside {issue_pkg::FN_MULT,
           issue_pkg::FN_MULTU, issue_pkg::FN_DIV, issue_pkg::FN_DIVU});
endfunction

function automatic bit uses_hilo(input logic [31:0] w);
    return is_muldiv(w) || ((w[31:26] == issue_pkg::OP_R_TYPE) && (w[5:0] inside
           {issue_pkg::FN_MFHI, issue_pkg::FN_MTHI, issue_pkg::FN_MFLO, issue_pkg::FN_MTLO}));
endfunction

function automatic bit is_system(input logic [31:0] w);
    return (w[31:26] == issue_pkg::OP_COP0) || ((w[31:26] == issue_pkg::OP_R_TYPE) &&
           (w[5:0] inside {issue_pkg::FN_SYSCALL, issue_pkg::FN_BREAK}));
endfunction

// Write enable in bit 5, destination register below it.
function automatic logic [5:0] dest_of(input logic [31:0] w);
    if (w[31:26] == issue_pkg::OP_R_TYPE) begin
        return {!(is_muldiv(w) || w[5:0] == issue_pkg::FN_JR), w[15:11]};
    end else if (is_load(w) || w[31:29] == 3'b001) begin
        return {1'b1, w[20:16]};
    end else if (w[31:26] == issue_pkg::OP_JAL) begin
        return {1'b1, 5'd31};
    end
    return 6'd0;
endfunction

function automatic bit load_use_hazard(input bit prev_valid, input logic [31:0] prev_w,
                                       input logic [31:0] s);
    return prev_valid && is_load(prev_w) &&
           ((s[25:21] == prev_w[20:16]) || (s[20:16] == prev_w[20:16]));
endfunction

function automatic bit slave_allowed(input logic [31:0] m, input logic [31:0] s,
                                     input bit prev_valid, input logic [31:0] prev_w,
                                     input bit two_queued);
    logic [5:0] md;
    bit         raw;
    md  = dest_of(m);
    raw = md[5] && (md[4:0] != 5'd0) && ((s[25:21] == md[4:0]) ||
          ((s[31:26] == issue_pkg::OP_R_TYPE) && (s[20:16] == md[4:0])));
    return two_queued && !accesses_memory(m) && !accesses_memory(s) && !is_branch(s) &&
           !uses_hilo(s) && !is_system(m) && !is_system(s) && !raw &&
           !load_use_hazard(prev_valid, prev_w, s);
endfunction

`endif

/* sim/tb_dual_issue.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_dual_issue;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 16;
    localparam int NUM_INSTR       = 400;  // Split over the two traffic tests.
    localparam int WATCHDOG_CYCLES = NUM_INSTR * 20 + RESET_CYCLES;

    logic                    clk;
    logic                    rst_n;
    logic                    fetch_valid;
    logic                    fetch_two;
    issue_pkg::fetch_entry_t fetch_entry0;
    issue_pkg::fetch_entry_t fetch_entry1;
    logic                    fetch_ready;
    logic                    exe_ready;
    issue_pkg::issue_pkt_t   exe_master;
    issue_pkg::issue_pkt_t   exe_slave;

    integer                  seed = 32'h9fbc064a;
    issue_pkg::fetch_entry_t pend[$];  // Pushed and not yet seen at the output.
    issue_pkg::issue_pkt_t   last_master;
    issue_pkg::issue_pkt_t   last_slave;
    logic [31:0]             next_pc;
    logic [31:0]             prev_word;
    bit                      prev_valid;
    bit                      lone_branch;  // Last master was a branch that went out alone.
    bit                      load_seen;  // Latch loads on the coming edge.
    int                      avail_cnt;
    int                      err_cnt;
    int                      tests_pass;
    int                      tests_fail;
    string                   test_name;

    dual_issue_top #(
        .QUEUE_DEPTH (8)
    ) dual_issue_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_valid  (fetch_valid),
        .fetch_two    (fetch_two),
        .fetch_entry0 (fetch_entry0),
        .fetch_entry1 (fetch_entry1),
        .fetch_ready  (fetch_ready),
        .exe_ready    (exe_ready),
        .exe_master   (exe_master),
        .exe_slave    (exe_slave)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Registers 0..3 only, so hazards show up often.
    function automatic logic [31:0] random_instr();
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        rs  = 5'(rand_below(4));
        rt  = 5'(rand_below(4));
        rd  = 5'(rand_below(4));
        imm = 16'(rand_below(65536));
        case (rand_below(14))
            0, 1:    return {6'h00, rs, rt, rd, 5'd0, 6'h21};  // addu
            2:       return {6'h09, rs, rt, imm};              // addiu
            3, 4:    return {6'h23, rs, rt, imm};              // lw
            5:       return {6'h2b, rs, rt, imm};              // sw
            6:       return {issue_pkg::OP_BEQ, rs, rt, imm};
            7:       return {issue_pkg::OP_J, rs, rt, imm};
            8:       return {issue_pkg::OP_JAL, rs, rt, imm};
            9:       return {6'h00, rs, 15'd0, issue_pkg::FN_JR};
            10:      return {6'h00, 10'd0, rd, 5'd0, issue_pkg::FN_MFHI};
            11:      return {6'h00, rs, rt, 10'd0, issue_pkg::FN_MULT};
            12:      return {6'h00, 20'd0, issue_pkg::FN_SYSCALL};
            default: return {issue_pkg::OP_COP0, 5'd0, rt, rd, 11'd0};
        endcase
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[ERROR] %s: %s expected 0x%08h actual 0x%08h", test_name, what, expected,
                 actual);
        err_cnt++;
    endtask

    task automatic report_failure(input string what);
        $display("%s: %s", test_name, what);
        err_cnt++;
    endtask

    // Payload of one exe packet against the entry it should carry.
    task automatic check_payload(input string slot, input issue_pkg::issue_pkt_t pkt,
                                 input issue_pkg::fetch_entry_t ent);
        logic [5:0] dest;
        dest = dest_of(ent.instr);
        assert (pkt.entry.pc === ent.pc)
            else report_mismatch({slot, " pc"}, ent.pc, pkt.entry.pc);
        assert (pkt.entry.instr === ent.instr)
            else report_mismatch({slot, " instr"}, ent.instr, pkt.entry.instr);
        assert ({pkt.reg_wen, pkt.reg_waddr} === dest)
            else report_mismatch({slot, " dest"}, 32'(dest),
                                 32'({pkt.reg_wen, pkt.reg_waddr}));
        assert (pkt.mem_to_reg === is_load(ent.instr))
            else report_mismatch({slot, " mem_to_reg"}, 32'(is_load(ent.instr)),
                                 32'(pkt.mem_to_reg));
    endtask

    task automatic check_cycle();
        issue_pkg::fetch_entry_t m_ent;
        logic [31:0]             s_word;
        bit                      exp_mv;
        bit                      exp_sv;
        if (load_seen) begin
            exp_mv = (avail_cnt > 0);
            assert (exe_master.valid === exp_mv)
                else report_mismatch("master valid", 32'(exp_mv), 32'(exe_master.valid));
            if (exp_mv) begin
                m_ent  = pend.pop_front();
                s_word = 32'd0;
                if (pend.size() > 0) begin
                    s_word = pend[0].instr;
                end
                exp_sv = slave_allowed(m_ent.instr, s_word, prev_valid, prev_word,
                                       avail_cnt >= 2);
                check_payload("master", exe_master, m_ent);
                assert (exe_master.in_delayslot === lone_branch)
                    else report_mismatch("master in_delayslot", 32'(lone_branch),
                                         32'(exe_master.in_delayslot));
                assert (exe_slave.valid === exp_sv)
                    else report_mismatch("slave valid", 32'(exp_sv), 32'(exe_slave.valid));
                assert (!(exe_slave.valid && load_use_hazard(prev_valid, prev_word, s_word)))
                    else report_failure("slave issued right behind a load it depends on");
                assert (exe_slave.in_delayslot === (exe_slave.valid && is_branch(m_ent.instr)))
                    else report_mismatch("slave in_delayslot",
                                         32'(exe_slave.valid && is_branch(m_ent.instr)),
                                         32'(exe_slave.in_delayslot));
                if (exe_slave.valid && pend.size() > 0) begin
                    check_payload("slave", exe_slave, pend[0]);
                    void'(pend.pop_front());
                end
                prev_word   = m_ent.instr;
                lone_branch = is_branch(m_ent.instr) && !exp_sv;
            end else begin
                assert (exe_slave.valid === 1'b0)
                    else report_mismatch("slave valid", 32'd0, 32'(exe_slave.valid));
                assert (exe_slave.in_delayslot === 1'b0)
                    else report_mismatch("slave in_delayslot", 32'd0,
                                         32'(exe_slave.in_delayslot));
            end
            prev_valid = exp_mv;
        end else begin
            assert (exe_master === last_master && exe_slave === last_slave)
                else report_failure("exe packets changed while exe_ready was low");
        end
        last_master = exe_master;
        last_slave  = exe_slave;
        load_seen   = exe_ready;
        avail_cnt   = pend.size();  // Entries pushed on the coming edge are not yet visible.
        if (fetch_valid && fetch_ready) begin
            pend.push_back(fetch_entry0);
            if (fetch_two) begin
                pend.push_back(fetch_entry1);
            end
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            check_cycle();
        end else begin
            load_seen   = 1'b0;
            prev_valid  = 1'b0;
            lone_branch = 1'b0;
            last_master = exe_master;
            last_slave  = exe_slave;
        end
    end

    task automatic send_instrs(input int total, input int ready_pct);
        int sent;
        sent = 0;
        while (sent < total) begin
            @(posedge clk);
            #1;
            exe_ready   = (rand_below(100) < ready_pct);
            fetch_valid = 1'b0;
            if (fetch_ready && rand_below(4) != 0) begin
                fetch_two          = (total - sent >= 2) && (rand_below(2) == 0);
                fetch_entry0.instr = random_instr();
                fetch_entry0.pc    = next_pc;
                fetch_entry1.instr = random_instr();
                fetch_entry1.pc    = next_pc + 32'd4;
                fetch_valid        = 1'b1;
                next_pc            = next_pc + (fetch_two ? 32'd8 : 32'd4);
                sent               = sent + (fetch_two ? 2 : 1);
            end
        end
        @(posedge clk);
        #1;
        fetch_valid = 1'b0;
        while (pend.size() != 0) begin
            @(posedge clk);
            #1;
            exe_ready = (rand_below(100) < ready_pct);
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic finish_test(input int errs_before);
        if (err_cnt == errs_before) begin
            tests_pass++;
            $display("Test %s: passed", test_name);
        end else begin
            tests_fail++;
            $display("Test %s: failed with %0d errors", test_name, err_cnt - errs_before);
        end
    endtask

    initial begin
        int errs;
        rst_n        = 1'b0;
        fetch_valid  = 1'b0;
        fetch_two    = 1'b0;
        fetch_entry0 = '0;
        fetch_entry1 = '0;
        exe_ready    = 1'b0;
        next_pc      = 32'h0000_1000;
        err_cnt      = 0;
        tests_pass   = 0;
        tests_fail   = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_name = "reset";
        errs      = err_cnt;
        @(negedge clk);
        assert (fetch_ready === 1'b1)
            else report_mismatch("fetch_ready", 32'd1, 32'(fetch_ready));
        assert (exe_master.valid === 1'b0)
            else report_mismatch("master valid", 32'd0, 32'(exe_master.valid));
        assert (exe_slave.valid === 1'b0)
            else report_mismatch("slave valid", 32'd0, 32'(exe_slave.valid));
        finish_test(errs);

        test_name = "full_rate";
        errs      = err_cnt;
        send_instrs(NUM_INSTR / 2, 100);
        finish_test(errs);

        test_name = "back_pressure";  // Execute stalls about 40% of the cycles.
        errs      = err_cnt;
        send_instrs(NUM_INSTR / 2, 60);
        finish_test(errs);

        $display("Tests passed: %0d, failed: %0d, errors: %0d", tests_pass, tests_fail,
                 err_cnt);
        if (tests_fail == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

`include "tb_issue_model.svh"

endmodule

`default_nettype wire

/* tb.f */
+incdir+sim
rtl/issue_pkg.sv
rtl/inst_queue.sv
rtl/inst_decode.sv
rtl/issue_ctrl.sv
rtl/exe_latch.sv
rtl/dual_issue_top.sv
sim/tb_dual_issue.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dual_issue
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= tb.f
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG) || (echo "No result in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
